// ==== fpu_pkg.sv ====
/*
 * fpu shared types: opcodes, rounding modes, exception flags
 * and the structs carried between the pipeline stages
 */
`default_nettype none

package fpu_pkg;

   // funct7 encodings, anything else decodes as add
   typedef enum logic [6:0] {
      OP_ADD = 7'b0000000,
      OP_SUB = 7'b0000100,
      OP_MUL = 7'b0001000
   } fpu_op_e;

   // risc-v static rounding modes, 5..7 fall back to rne
   typedef enum logic [2:0] {
      RM_RNE = 3'd0,
      RM_RTZ = 3'd1,
      RM_RDN = 3'd2,
      RM_RUP = 3'd3,
      RM_RMM = 3'd4
   } round_mode_e;

   typedef struct packed {
      logic nv;   // invalid
      logic dz;   // divide by zero, unused here
      logic of;
      logic uf;
      logic nx;   // inexact
   } fpu_flags_t;

   // stage 1 register
   typedef struct packed {
      fpu_op_e            op;
      round_mode_e        rm;
      logic               sign_a;
      logic               sign_b;          // already flipped for sub
      logic signed [9:0]  exp;             // max exp (add) or ea+eb-127 (mul)
      logic [26:0]        mant_a;          // 1.23 + g r s
      logic [26:0]        mant_b;
      logic               is_special;
      logic [31:0]        special_value;
      logic               special_nv;
   } unpacked_t;

   // unrounded core result
   typedef struct packed {
      logic               sign;
      logic signed [9:0]  exp;
      logic [26:0]        mant;            // 1.23 + g r s
      logic               is_zero;
      fpu_op_e            op;
      round_mode_e        rm;
   } norm_t;

   localparam logic [31:0] QNAN = 32'h7fc00000;

endpackage

`default_nettype wire

// ==== fpu_unpack.sv ====
/*
 * fpu input stage: decodes and classifies both operands, aligns the
 * addends, resolves special cases and registers stage 1
 */
`timescale 1ns/1ps
`default_nettype none

module fpu_unpack (
   input  logic                 clk,
   input  logic                 nrst,
   input  logic                 start,
   input  logic [31:0]          op_a,
   input  logic [31:0]          op_b,
   input  fpu_pkg::fpu_op_e     funct7,
   input  fpu_pkg::round_mode_e frm,
   output fpu_pkg::unpacked_t   s1,
   output logic                 s1_valid
);
   import fpu_pkg::*;

   fpu_op_e     op_n;
   round_mode_e rm_n;
   logic        sa;
   logic        sb;
   logic [7:0]  ea;
   logic [7:0]  eb;
   logic        a_zero, b_zero;
   logic        a_inf, b_inf;
   logic        a_nan, b_nan;
   logic        any_snan;
   logic [23:0] ma, mb;
   logic        swap;
   logic [7:0]  e_big;
   logic [7:0]  diff;
   logic [4:0]  shamt;
   logic [26:0] m_big, m_small;
   logic [53:0] wide;           // shifted small mantissa, spill below bit 27
   unpacked_t   s1_d;

   always_comb begin
      case (funct7)
         OP_SUB:  op_n = OP_SUB;
         OP_MUL:  op_n = OP_MUL;
         default: op_n = OP_ADD;
      endcase
      rm_n = (frm > RM_RMM) ? RM_RNE : frm;
   end

   assign sa = op_a[31];
   assign sb = op_b[31] ^ (op_n == OP_SUB);   // effective sign of b
   assign ea = op_a[30:23];
   assign eb = op_b[30:23];

   // zero exponent counts as zero, subnormals included
   assign a_zero = (ea == 8'd0);
   assign b_zero = (eb == 8'd0);
   assign a_inf  = (ea == 8'hff) && (op_a[22:0] == 23'd0);
   assign b_inf  = (eb == 8'hff) && (op_b[22:0] == 23'd0);
   assign a_nan  = (ea == 8'hff) && (op_a[22:0] != 23'd0);
   assign b_nan  = (eb == 8'hff) && (op_b[22:0] != 23'd0);
   assign any_snan = (a_nan && !op_a[22]) || (b_nan && !op_b[22]);

   assign ma = a_zero ? 24'd0 : {1'b1, op_a[22:0]};
   assign mb = b_zero ? 24'd0 : {1'b1, op_b[22:0]};

   // larger magnitude goes first
   assign swap    = (b_zero ? 31'd0 : op_b[30:0]) > (a_zero ? 31'd0 : op_a[30:0]);
   assign e_big   = swap ? eb : ea;
   assign diff    = swap ? (eb - ea) : (ea - eb);
   assign shamt   = (diff > 8'd27) ? 5'd27 : diff[4:0];
   assign m_big   = swap ? {mb, 3'b000} : {ma, 3'b000};
   assign m_small = swap ? {ma, 3'b000} : {mb, 3'b000};
   assign wide    = {m_small, 27'd0} >> shamt;

   always_comb begin
      s1_d = '0;
      s1_d.op = op_n;
      s1_d.rm = rm_n;
      if (op_n == OP_MUL) begin
         s1_d.sign_a = sa;
         s1_d.sign_b = sb;
         s1_d.exp    = $signed({2'b00, ea}) + $signed({2'b00, eb}) - 10'sd127;
         s1_d.mant_a = {3'b000, ma};
         s1_d.mant_b = {3'b000, mb};
         if (a_nan || b_nan) begin
            s1_d.is_special    = 1'b1;
            s1_d.special_value = QNAN;
            s1_d.special_nv    = any_snan;
         end else if ((a_inf && b_zero) || (a_zero && b_inf)) begin
            s1_d.is_special    = 1'b1;
            s1_d.special_value = QNAN;
            s1_d.special_nv    = 1'b1;
         end else if (a_inf || b_inf) begin
            s1_d.is_special    = 1'b1;
            s1_d.special_value = {sa ^ sb, 8'hff, 23'd0};
         end else if (a_zero || b_zero) begin
            s1_d.is_special    = 1'b1;
            s1_d.special_value = {sa ^ sb, 31'd0};
         end
      end else begin
         s1_d.sign_a = swap ? sb : sa;
         s1_d.sign_b = swap ? sa : sb;
         s1_d.exp    = $signed({2'b00, e_big});
         s1_d.mant_a = m_big;
         s1_d.mant_b = {wide[53:28], wide[27] | (|wide[26:0])};   // fold into sticky
         if (a_nan || b_nan) begin
            s1_d.is_special    = 1'b1;
            s1_d.special_value = QNAN;
            s1_d.special_nv    = any_snan;
         end else if (a_inf && b_inf && (sa != sb)) begin
            s1_d.is_special    = 1'b1;
            s1_d.special_value = QNAN;
            s1_d.special_nv    = 1'b1;
         end else if (a_inf || b_inf) begin
            s1_d.is_special    = 1'b1;
            s1_d.special_value = {a_inf ? sa : sb, 8'hff, 23'd0};
         end else if (a_zero && b_zero) begin
            // -0 only when both negative, or opposite signs under rdn
            s1_d.is_special    = 1'b1;
            s1_d.special_value = {(sa == sb) ? sa : (rm_n == RM_RDN), 31'd0};
         end
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= start;
      end
   end

   always_ff @(posedge clk) begin
      s1 <= s1_d;
   end

endmodule

`default_nettype wire

// ==== fpu_add_core.sv ====
/*
 * fpu add/sub core: adds or subtracts the aligned mantissas and
 * normalises the sum, keeping guard, round and sticky
 */
`timescale 1ns/1ps
`default_nettype none

module fpu_add_core (
   input  fpu_pkg::unpacked_t s1,
   output fpu_pkg::norm_t     res
);
   import fpu_pkg::*;

   logic              eff_sub;
   logic [27:0]       sum;        // one carry bit above 1.23 grs
   logic              exact_zero;
   logic [4:0]        lz;
   logic [26:0]       shifted;

   // leading zeros of the 27-bit sum, 27 when all clear
   function automatic logic [4:0] lzc27(input logic [26:0] v);
      logic [4:0] n;
      logic       found;
      n = 5'd27;
      found = 1'b0;
      for (int i = 26; i >= 0; i--) begin
         if (!found && v[i]) begin
            n = 5'(26 - i);
            found = 1'b1;
         end
      end
      return n;
   endfunction

   assign eff_sub = s1.sign_a ^ s1.sign_b;

   // mant_a is never smaller, so no negative result
   assign sum = eff_sub ? ({1'b0, s1.mant_a} - {1'b0, s1.mant_b})
                        : ({1'b0, s1.mant_a} + {1'b0, s1.mant_b});

   assign exact_zero = (sum == 28'd0);
   assign lz         = lzc27(sum[26:0]);
   assign shifted    = sum[26:0] << lz;

   always_comb begin
      res         = '0;
      res.op      = s1.op;
      res.rm      = s1.rm;
      res.is_zero = exact_zero;
      if (exact_zero) begin
         res.sign = (s1.rm == RM_RDN);   // x - x is +0 except rdn
         res.exp  = 10'sd0;
         res.mant = 27'd0;
      end else if (sum[27]) begin
         // carry out, shift right one and keep sticky
         res.sign = s1.sign_a;
         res.exp  = $signed(s1.exp) + 10'sd1;
         res.mant = {sum[27:2], sum[1] | sum[0]};
      end else begin
         // cancellation, shift left by lz
         res.sign = s1.sign_a;
         res.exp  = $signed(s1.exp) - $signed({5'd0, lz});
         res.mant = shifted;
      end
   end

endmodule

`default_nettype wire

// ==== fpu_mul_core.sv ====
/*
 * fpu multiply core: 24x24 significand product with one-bit
 * normalisation and guard/round/sticky collapse
 */
`timescale 1ns/1ps
`default_nettype none

module fpu_mul_core (
   input  fpu_pkg::unpacked_t s1,
   output fpu_pkg::norm_t     res
);
   import fpu_pkg::*;

   logic [47:0] prod;     // 2.46 fixed point
   logic [23:0] m;
   logic        guard;
   logic        rnd;
   logic        sticky;

   assign prod = {24'd0, s1.mant_a[23:0]} * {24'd0, s1.mant_b[23:0]};

   always_comb begin
      if (prod[47]) begin
         // product in [2,4)
         m      = prod[47:24];
         guard  = prod[23];
         rnd    = prod[22];
         sticky = |prod[21:0];
      end else begin
         m      = prod[46:23];
         guard  = prod[22];
         rnd    = prod[21];
         sticky = |prod[20:0];
      end
   end

   // zero operands go the special path, so is_zero stays clear
   always_comb begin
      res         = '0;
      res.sign    = s1.sign_a ^ s1.sign_b;
      res.exp     = $signed(s1.exp) + $signed({9'd0, prod[47]});
      res.mant    = {m, guard, rnd, sticky};
      res.op      = s1.op;
      res.rm      = s1.rm;
   end

endmodule

`default_nettype wire

// ==== fpu_round_pack.sv ====
/*
 * fpu output side: picks the core result into stage 2, then rounds,
 * applies overflow/underflow and registers result, flags and ready
 */
`timescale 1ns/1ps
`default_nettype none

module fpu_round_pack (
   input  logic                 clk,
   input  logic                 nrst,
   input  fpu_pkg::unpacked_t   s1,
   input  logic                 s1_valid,
   input  fpu_pkg::norm_t       add_res,
   input  fpu_pkg::norm_t       mul_res,
   output logic [31:0]          result,
   output fpu_pkg::fpu_flags_t  flags,
   output logic                 ready
);
   import fpu_pkg::*;

   norm_t             s2_d;
   norm_t             s2;
   logic              s2_valid;
   logic              s2_special;
   logic [31:0]       s2_special_value;
   logic              s2_special_nv;

   logic              lsb, guard, rnd, sticky;
   logic              inexact;
   logic              inc;
   logic [24:0]       rounded;       // 1.23 plus carry
   logic signed [9:0] exp_r;
   logic              max_finite;
   logic [31:0]       result_d;
   fpu_flags_t        flags_d;

   assign s2_d = (s1.op == OP_MUL) ? mul_res : add_res;

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         s2_valid <= 1'b0;
      end else begin
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      s2               <= s2_d;
      s2_special       <= s1.is_special;
      s2_special_value <= s1.special_value;
      s2_special_nv    <= s1.special_nv;
   end

   assign lsb     = s2.mant[3];
   assign guard   = s2.mant[2];
   assign rnd     = s2.mant[1];
   assign sticky  = s2.mant[0];
   assign inexact = guard | rnd | sticky;

   always_comb begin
      case (s2.rm)
         RM_RTZ:  inc = 1'b0;
         RM_RDN:  inc = s2.sign & inexact;
         RM_RUP:  inc = ~s2.sign & inexact;
         RM_RMM:  inc = guard;                          // ties away
         default: inc = guard & (rnd | sticky | lsb);   // ties to even
      endcase
   end

   assign rounded = {1'b0, s2.mant[26:3]} + {24'd0, inc};
   assign exp_r   = $signed(s2.exp) + $signed({9'd0, rounded[24]});   // renormalise

   // modes that never round past the largest finite value for this sign
   assign max_finite = (s2.rm == RM_RTZ) || ((s2.rm == RM_RDN) && !s2.sign) ||
                       ((s2.rm == RM_RUP) && s2.sign);

   always_comb begin
      flags_d = '0;
      if (s2_special) begin
         result_d   = s2_special_value;
         flags_d.nv = s2_special_nv;
      end else if (s2.is_zero) begin
         result_d = {s2.sign, 31'd0};   // exact cancellation
      end else if ($signed(s2.exp) < 10'sd1) begin
         result_d   = {s2.sign, 31'd0};   // flush
         flags_d.uf = 1'b1;
         flags_d.nx = 1'b1;
      end else if (exp_r >= 10'sd255) begin
         result_d   = max_finite ? {s2.sign, 8'hfe, 23'h7fffff} : {s2.sign, 8'hff, 23'd0};
         flags_d.of = 1'b1;
         flags_d.nx = 1'b1;
      end else begin
         result_d   = {s2.sign, exp_r[7:0], rounded[24] ? rounded[23:1] : rounded[22:0]};
         flags_d.nx = inexact;
      end
   end

   always_ff @(posedge clk or negedge nrst) begin
      if (!nrst) begin
         result <= 32'd0;
         flags  <= '0;
         ready  <= 1'b0;
      end else begin
         ready <= s2_valid;
         if (s2_valid) begin
            result <= result_d;
            flags  <= flags_d;
         end
      end
   end

endmodule

`default_nettype wire

// ==== fpu_top.sv ====
/*
 * three-stage binary32 fpu, add/sub/mul with risc-v rounding modes,
 * result and flags three cycles after start
 */
`timescale 1ns/1ps
`default_nettype none

module fpu_top (
   input  logic                 clk,
   input  logic                 nrst,
   input  logic                 start,
   input  logic [31:0]          op_a,
   input  logic [31:0]          op_b,
   input  fpu_pkg::fpu_op_e     funct7,
   input  fpu_pkg::round_mode_e frm,
   output logic [31:0]          result,
   output fpu_pkg::fpu_flags_t  flags,
   output logic                 ready
);
   import fpu_pkg::*;

   unpacked_t s1;
   logic      s1_valid;
   norm_t     add_res;
   norm_t     mul_res;

   fpu_unpack u_unpack (
      .clk      (clk),
      .nrst     (nrst),
      .start    (start),
      .op_a     (op_a),
      .op_b     (op_b),
      .funct7   (funct7),
      .frm      (frm),
      .s1       (s1),
      .s1_valid (s1_valid)
   );

   // both cores see every operation, selection happens downstream
   fpu_add_core u_add_core (
      .s1  (s1),
      .res (add_res)
   );

   fpu_mul_core u_mul_core (
      .s1  (s1),
      .res (mul_res)
   );

   fpu_round_pack u_round_pack (
      .clk      (clk),
      .nrst     (nrst),
      .s1       (s1),
      .s1_valid (s1_valid),
      .add_res  (add_res),
      .mul_res  (mul_res),
      .result   (result),
      .flags    (flags),
      .ready    (ready)
   );

endmodule

`default_nettype wire

// ==== tb_fpu.sv ====
/*
 * fpu testbench: plays golden vectors with random idle gaps and checks
 * result, flags and the three-cycle start to ready latency
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fpu;
   import fpu_pkg::*;

   localparam int MAX_VEC = 64;
   localparam int COLS    = 7;    // group, funct7, frm, op_a, op_b, result, flags
   localparam int NGRP    = 6;

   logic        clk = 1'b0;
   logic        nrst;
   logic        start;
   logic [31:0] op_a;
   logic [31:0] op_b;
   fpu_op_e     funct7;
   round_mode_e frm;
   logic [31:0] result;
   fpu_flags_t  flags;
   logic        ready;

   logic [31:0] vec_mem [0:MAX_VEC*COLS-1];
   int          nvec = 0;
   int          cyc = 0;
   int          limit = 0;
   int          errors = 0;
   int          checks = 0;
   int          done_cnt = 0;
   int          grp_expected [NGRP];
   int          grp_total [NGRP];
   int          grp_err [NGRP];
   logic [7:0]  lfsr;

   // expected values in start order
   logic [31:0] exp_res_q [$];
   logic [4:0]  exp_flg_q [$];
   int          start_cyc_q [$];
   int          vec_idx_q [$];

   fpu_top dut (
      .clk    (clk),
      .nrst   (nrst),
      .start  (start),
      .op_a   (op_a),
      .op_b   (op_b),
      .funct7 (funct7),
      .frm    (frm),
      .result (result),
      .flags  (flags),
      .ready  (ready)
   );

   always #20 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic [7:0] lfsr_next(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);   // x^8+x^6+x^5+x^4+1
   endfunction

   function automatic string group_name(input int g);
      case (g)
         0:       return "reset";
         1:       return "add/sub";
         2:       return "mul";
         3:       return "special operands";
         4:       return "overflow/underflow";
         default: return "back-to-back";
      endcase
   endfunction

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] expected);
      checks++;
      if (got !== expected) begin
         errors++;
         $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, expected);
      end
   endtask

   // two lfsr bits give 0..3 idle cycles
   task automatic draw_gap(output int gap);
      gap = 0;
      repeat (2) begin
         gap = gap * 2 + int'(lfsr[0]);
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic check_idle();
      compare_value("idle ready", 32'(ready), 32'd0);
      compare_value("idle result", result, 32'd0);
      compare_value("idle flags", {27'd0, flags}, 32'd0);
   endtask

   task automatic apply_vector(input int i);
      int base;
      base   = i * COLS;
      funct7 = fpu_op_e'(vec_mem[base+1][6:0]);
      frm    = round_mode_e'(vec_mem[base+2][2:0]);
      op_a   = vec_mem[base+3];
      op_b   = vec_mem[base+4];
      start  = 1'b1;
      exp_res_q.push_back(vec_mem[base+5]);
      exp_flg_q.push_back(vec_mem[base+6][4:0]);
      start_cyc_q.push_back(cyc);   // cycle in which start is high
      vec_idx_q.push_back(i);
   endtask

   // monitor, outputs are stable at the falling edge
   always @(negedge clk) begin
      int idx;
      int g;
      int err_before;
      if (nrst && ready) begin
         if (vec_idx_q.size() == 0) begin
            errors++;
            $display("ERROR at %0t: ready pulse with no operation in flight", $time);
         end else begin
            idx        = vec_idx_q.pop_front();
            g          = int'(vec_mem[idx*COLS]);
            err_before = errors;
            compare_value($sformatf("vector %0d result", idx), result, exp_res_q.pop_front());
            compare_value($sformatf("vector %0d flags", idx), {27'd0, flags},
                          {27'd0, exp_flg_q.pop_front()});
            compare_value($sformatf("vector %0d latency", idx),
                          32'(cyc - start_cyc_q.pop_front()), 32'd3);
            grp_total[g]++;
            if (errors != err_before) grp_err[g]++;
            done_cnt++;
            if (grp_total[g] == grp_expected[g])
               $display("%s: %0d vectors, %0d failed", group_name(g), grp_total[g], grp_err[g]);
         end
      end
   end

   // watchdog, limit is set once the vectors are loaded
   always @(posedge clk) begin
      if (limit > 0 && cyc > limit) begin
         $display("timeout: %0d of %0d results arrived within %0d cycles", done_cnt, nvec, limit);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      int gap;
      int err_before;
      nrst   = 1'b0;
      start  = 1'b0;
      op_a   = 32'd0;
      op_b   = 32'd0;
      funct7 = OP_ADD;
      frm    = RM_RNE;
      lfsr   = 8'd59;
      $readmemh("fpu_golden.hex", vec_mem);
      while (nvec < MAX_VEC && vec_mem[nvec*COLS+1] != 32'hff) begin
         grp_expected[int'(vec_mem[nvec*COLS])]++;
         nvec++;
      end
      limit = nvec * 5 + 50;

      err_before = errors;
      repeat (8) begin
         @(negedge clk);
         check_idle();
      end
      @(posedge clk);
      #2 nrst = 1'b1;
      repeat (2) begin   // no ready may show up before the first start
         @(negedge clk);
         check_idle();
      end
      $display("%s: %0d checks, %0d failed", group_name(0), checks, errors - err_before);

      for (int i = 0; i < nvec; i++) begin
         @(posedge clk);
         #2;
         apply_vector(i);
         if (int'(vec_mem[i*COLS]) == 5) gap = 0;   // burst group
         else draw_gap(gap);
         repeat (gap) begin
            @(posedge clk);
            #2 start = 1'b0;
         end
      end
      @(posedge clk);
      #2 start = 1'b0;

      wait (done_cnt == nvec);
      repeat (5) @(negedge clk);   // catch stray ready pulses

      if (nvec == 0) begin
         errors++;
         $display("ERROR: no vectors were read from fpu_golden.hex");
      end
      $display("vectors %0d of %0d, checks %0d, errors %0d", done_cnt, nvec, checks, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== fpu_golden.hex ====
// group funct7 frm op_a op_b result flags(nv dz of uf nx)
// groups 1 add/sub, 2 mul, 3 special operands, 4 overflow/underflow, 5 back-to-back
1 00 0 3f800000 40000000 40400000 00
1 04 0 3f800000 40400000 c0000000 00
1 04 0 3fc00000 3fc00000 00000000 00
1 04 2 3fc00000 3fc00000 80000000 00
1 04 0 3f800000 3f7fffff 33800000 00
1 00 0 3f800000 33800000 3f800000 01
1 00 3 3f800000 33800000 3f800001 01
1 00 4 3f800000 33800000 3f800001 01
1 00 7 3f800001 33800000 3f800002 01
1 04 2 bf800000 33800000 bf800001 01
1 04 0 3f800000 33000000 3f800000 01
2 08 0 40000000 40400000 40c00000 00
2 08 0 3fc00000 3fc00000 40100000 00
2 08 0 bfc00000 40000000 c0400000 00
2 08 3 3f800001 3f800001 3f800003 01
2 08 0 3fffffff 3fffffff 407ffffe 01
2 08 4 3fc00000 3f800001 3fc00002 01
3 00 0 7fc00000 3f800000 7fc00000 00
3 08 0 7f800001 40000000 7fc00000 10
3 04 0 7f800000 7f800000 7fc00000 10
3 08 0 00000000 ff800000 7fc00000 10
3 00 0 7f800000 3f800000 7f800000 00
3 00 0 80000000 80000000 80000000 00
3 04 2 00000000 00000000 80000000 00
3 00 0 00400000 3f800000 3f800000 00
4 08 0 7f7fffff 40000000 7f800000 05
4 08 1 7f7fffff 40000000 7f7fffff 05
4 08 3 ff7fffff 40000000 ff7fffff 05
4 00 0 7f7fffff 73000000 7f800000 05
4 00 1 7f7fffff 73000000 7f7fffff 01
4 08 0 9f800000 1f800000 80000000 03
4 04 0 00800001 00800000 00000000 03
4 08 0 00800000 3f800000 00800000 00
5 00 0 40400000 40000000 40a00000 00
5 08 0 40a00000 40000000 41200000 00
5 04 0 41200000 40a00000 40a00000 00
5 00 0 3f800000 bf800000 00000000 00
5 08 0 7fc00000 3f800000 7fc00000 00
5 00 3 3f800000 33800000 3f800001 01
// end marker, funct7 ff
0 ff 0 00000000 00000000 00000000 00

// ==== fpu.f ====
fpu_pkg.sv
fpu_unpack.sv
fpu_add_core.sv
fpu_mul_core.sv
fpu_round_pack.sv
fpu_top.sv
tb_fpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_fpu
FILELIST  = fpu.f
OBJDIR    = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
